// ==== files.f ====
+incdir+verilog
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/regfile.sv
verilog/execute_stage.sv
verilog/core_top.sv
verification/core_properties.sv
verification/core_tb.sv

// ==== verification/core_properties.sv ====
`default_nettype none
`timescale 1ns/1ps

module core_properties import pipe_pkg::*; (
    input wire logic        clk,
    input wire logic        resetn,
    input wire logic        hold,
    input wire logic [31:0] inst_addr,
    input wire logic        retire_valid,
    input wire retire_t     retire,
    input wire logic        es_valid
);

    no_retire_in_hold: assert property (@(posedge clk) disable iff (!resetn)
        hold |-> !retire_valid)
        else $error("retire_valid asserted while hold is high");

    // a stalled instruction keeps its trace word
    retire_stable_in_hold: assert property (@(posedge clk) disable iff (!resetn)
        es_valid && hold |=> $stable(retire))
        else $error("retire word changed during hold");

    fetch_aligned: assert property (@(posedge clk) disable iff (!resetn)
        inst_addr[1:0] == 2'b00)
        else $error("fetch address not word aligned");

    quiet_after_reset: assert property (@(posedge clk)
        $rose(resetn) |-> !retire_valid)
        else $error("retire_valid high in the first cycle after reset");

endmodule

bind core_top core_properties core_properties_inst (
    .clk          (clk),
    .resetn       (resetn),
    .hold         (hold),
    .inst_addr    (inst_addr),
    .retire_valid (retire_valid),
    .retire       (retire),
    .es_valid     (execute_stage_inst.es_valid)
);

`default_nettype wire

// ==== verification/core_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "core_params.svh"

module core_tb import pipe_pkg::*;;

    localparam int IMEM_WORDS      = 256;
    localparam int TOTAL_INSTR     = 123;
    localparam int MAX_HOLD_CYCLES = 150;
    localparam int TIMEOUT_CYCLES  = TOTAL_INSTR * 4 + MAX_HOLD_CYCLES + 100;
    localparam logic [31:0] HALT   = 32'h5000_0000;   // b with zero offset

    logic        clk = 1'b0;
    logic        resetn;
    logic        hold;
    logic [31:0] inst_addr;
    logic [31:0] inst_rdata;
    logic        retire_valid;
    retire_t     retire;

    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] imem_offs;
    logic [31:0] prog [$];
    retire_t     exp_q [$];
    logic [31:0] rng_state;
    int          cycle_count;

    core_top core_top_inst (
        .clk          (clk),
        .resetn       (resetn),
        .inst_addr    (inst_addr),
        .inst_rdata   (inst_rdata),
        .hold         (hold),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    always #2 clk = ~clk;

    assign imem_offs  = inst_addr - `RESET_PC;
    assign inst_rdata = imem[imem_offs[9:2]];   // same-cycle answer

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        stop_with_failure($sformatf("mismatch %s: got 0x%08h expected 0x%08h", name, got, want));
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES)
            stop_with_failure("timeout: retire trace did not complete in time");
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // instruction encoders with branch offsets in words
    function automatic logic [31:0] enc_3r(input logic [4:0] func, rd, rj, rk);
        return {12'h001, func, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_shi(input logic [4:0] func, rd, rj, ui5);
        return {12'h004, func, ui5, rj, rd};
    endfunction

    function automatic logic [31:0] enc_i12(input logic [3:0] op, input logic [4:0] rd, rj,
                                            input logic [11:0] imm);
        return {6'h00, op, imm, rj, rd};
    endfunction

    function automatic logic [31:0] enc_u20(input logic [6:0] op, input logic [4:0] rd,
                                            input logic [19:0] imm);
        return {op, imm, rd};
    endfunction

    function automatic logic [31:0] enc_b16(input logic [5:0] op, input logic [4:0] rj, rd,
                                            input logic [15:0] offs);
        return {op, offs, rj, rd};
    endfunction

    function automatic logic [31:0] enc_b26(input logic [5:0] op, input logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    task automatic emit(input logic [31:0] w);
        prog.push_back(w);
    endtask

    task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
        emit(enc_u20(7'b0001010, rd, v[31:12]));
        emit(enc_i12(4'he, rd, rd, v[11:0]));
    endtask

    // ISA reference model stepping the loaded program up to the halt word
    task automatic model_run();
        logic [31:0] r [`NUM_REGS];
        logic [31:0] pc, w, a, b, res, nxt, si12, ui12, off16, off26;
        logic [31:0] offs;
        logic        we;
        logic [4:0]  waddr;
        retire_t     entry;
        int          steps;
        for (int i = 0; i < `NUM_REGS; i++)
            r[i] = 32'd0;
        exp_q.delete();
        pc = `RESET_PC;
        steps = 0;
        while (1) begin
            offs  = pc - `RESET_PC;
            w     = imem[offs[9:2]];
            a     = r[w[9:5]];
            b     = r[w[14:10]];
            si12  = {{20{w[21]}}, w[21:10]};
            ui12  = {20'b0, w[21:10]};
            off16 = {{14{w[25]}}, w[25:10], 2'b0};
            off26 = {{4{w[9]}}, w[9:0], w[25:10], 2'b0};
            we    = 1'b1;
            waddr = w[4:0];
            res   = 32'd0;
            nxt   = pc + 32'd4;
            if (w[31:20] == 12'h001) begin
                case (w[19:15])
                    5'h00: res = a + b;
                    5'h02: res = a - b;
                    5'h04: res = {31'b0, $signed(a) < $signed(b)};
                    5'h05: res = {31'b0, a < b};
                    5'h08: res = ~(a | b);
                    5'h09: res = a & b;
                    5'h0a: res = a | b;
                    5'h0b: res = a ^ b;
                    5'h0e: res = a << b[4:0];
                    5'h0f: res = a >> b[4:0];
                    default: res = $signed(a) >>> b[4:0];
                endcase
            end else if (w[31:20] == 12'h004) begin
                case (w[19:15])
                    5'h01: res = a << w[14:10];
                    5'h09: res = a >> w[14:10];
                    default: res = $signed(a) >>> w[14:10];
                endcase
            end else if (w[31:26] == 6'h00) begin
                case (w[25:22])
                    4'h8: res = {31'b0, $signed(a) < $signed(si12)};
                    4'h9: res = {31'b0, a < si12};
                    4'ha: res = a + si12;
                    4'hd: res = a & ui12;
                    4'he: res = a | ui12;
                    default: res = a ^ ui12;
                endcase
            end else if (w[31:25] == 7'b0001010) begin
                res = {w[24:5], 12'b0};
            end else if (w[31:25] == 7'b0001110) begin
                res = pc + {w[24:5], 12'b0};
            end else begin
                case (w[31:26])
                    6'h13: begin
                        res = pc + 32'd4;
                        nxt = a + off16;
                    end
                    6'h14: begin
                        we  = 1'b0;
                        nxt = pc + off26;
                    end
                    6'h15: begin
                        res   = pc + 32'd4;
                        waddr = 5'd1;
                        nxt   = pc + off26;
                    end
                    6'h16: begin
                        we = 1'b0;
                        if (a == r[w[4:0]])
                            nxt = pc + off16;
                    end
                    6'h17: begin
                        we = 1'b0;
                        if (a != r[w[4:0]])
                            nxt = pc + off16;
                    end
                    default: stop_with_failure("reference model met an unsupported instruction");
                endcase
            end
            entry = '{pc: pc, we: we, waddr: waddr, wdata: res};
            exp_q.push_back(entry);
            if (we && waddr != 5'd0)
                r[waddr] = res;
            if (w == HALT)
                break;
            pc = nxt;
            steps++;
            if (steps > IMEM_WORDS)
                stop_with_failure("reference model never reached the halt instruction");
        end
    endtask

    task automatic check_retire(input retire_t want);
        assert (retire.pc == want.pc)
            else report_mismatch("retire.pc", retire.pc, want.pc);
        assert (retire.we == want.we)
            else report_mismatch("retire.we", 32'(retire.we), 32'(want.we));
        if (want.we) begin
            assert (retire.waddr == want.waddr)
                else report_mismatch("retire.waddr", 32'(retire.waddr), 32'(want.waddr));
            assert (retire.wdata == want.wdata)
                else report_mismatch("retire.wdata", retire.wdata, want.wdata);
        end
    endtask

    // reset, load, then compare every retire against the model
    task automatic run_program(input bit random_hold);
        int          idx;
        int          hold_used;
        int          waited;
        int          wait_limit;
        logic [31:0] rnd;
        @(negedge clk);
        resetn = 1'b0;
        hold   = 1'b0;
        for (int i = 0; i < IMEM_WORDS; i++)
            imem[i] = 32'hfc00_0000 ^ (`RESET_PC + 32'(i) * 4);
        for (int i = 0; i < prog.size(); i++)
            imem[i] = prog[i];
        model_run();
        repeat (10) begin
            @(negedge clk);
            assert (!retire_valid) else stop_with_failure("retire_valid high during reset");
        end
        resetn     = 1'b1;
        idx        = 0;
        hold_used  = 0;
        waited     = 0;
        wait_limit = exp_q.size() * 4 + (random_hold ? MAX_HOLD_CYCLES : 0);
        while (idx < exp_q.size() && waited < wait_limit) begin
            @(negedge clk);
            waited++;
            rnd  = next_rand();
            hold = random_hold && hold_used < MAX_HOLD_CYCLES && rnd[0];
            if (hold)
                hold_used++;
            #1;
            if (retire_valid) begin
                check_retire(exp_q[idx]);
                idx++;
            end
        end
        assert (idx == exp_q.size())
            else stop_with_failure("retire trace stopped before the last expected instruction");
        hold = 1'b0;
        prog.delete();
    endtask

    task automatic alu_body();
        logic [4:0] funcs [11] = '{5'h00, 5'h02, 5'h04, 5'h05, 5'h08, 5'h09,
                                  5'h0a, 5'h0b, 5'h0e, 5'h0f, 5'h10};
        logic [3:0] iops [6] = '{4'h8, 4'h9, 4'ha, 4'hd, 4'he, 4'hf};
        logic [31:0] rnd;
        for (int i = 1; i <= 4; i++)
            load_const(5'(i), next_rand());
        for (int i = 0; i < 11; i++)
            emit(enc_3r(funcs[i], 5'(5 + i), 5'(1 + i % 4), 5'(1 + (i + 1) % 4)));
        rnd = next_rand();
        emit(enc_shi(5'h01, 5'd16, 5'd1, rnd[4:0]));
        emit(enc_shi(5'h09, 5'd17, 5'd2, rnd[9:5]));
        emit(enc_shi(5'h11, 5'd18, 5'd3, rnd[14:10]));
        for (int i = 0; i < 6; i++) begin
            rnd = next_rand();
            emit(enc_i12(iops[i], 5'(19 + i), 5'(1 + i % 4), rnd[11:0]));
        end
    endtask

    task automatic forwarding_body();
        emit(enc_i12(4'ha, 5'd1, 5'd0, 12'h123));
        emit(enc_3r(5'h00, 5'd2, 5'd1, 5'd1));
        emit(enc_3r(5'h02, 5'd3, 5'd2, 5'd1));
        emit(enc_3r(5'h0b, 5'd4, 5'd3, 5'd2));
        emit(enc_u20(7'b0001010, 5'd5, 20'habcde));
        emit(enc_u20(7'b0001110, 5'd6, 20'h00012));
        emit(enc_3r(5'h00, 5'd7, 5'd6, 5'd5));
        emit(enc_i12(4'ha, 5'd0, 5'd1, 12'h007));   // r0 must stay zero
        emit(enc_3r(5'h00, 5'd8, 5'd0, 5'd1));
        emit(enc_3r(5'h0a, 5'd9, 5'd0, 5'd0));
        emit(enc_i12(4'ha, 5'd9, 5'd9, 12'hfff));
    endtask

    task automatic branch_body();
        emit(enc_i12(4'ha, 5'd10, 5'd0, 12'd5));
        emit(enc_i12(4'ha, 5'd11, 5'd0, 12'd5));
        emit(enc_b16(6'h16, 5'd10, 5'd11, 16'd2));   // beq taken
        emit(enc_i12(4'ha, 5'd12, 5'd0, 12'd1));
        emit(enc_b16(6'h17, 5'd10, 5'd11, 16'd2));   // bne not taken
        emit(enc_i12(4'ha, 5'd12, 5'd0, 12'd2));
        emit(enc_b16(6'h16, 5'd10, 5'd12, 16'd2));   // beq not taken
        emit(enc_b16(6'h17, 5'd10, 5'd12, 16'd2));   // bne taken
        emit(enc_i12(4'ha, 5'd13, 5'd0, 12'd3));
        emit(enc_b26(6'h14, 26'd2));
        emit(enc_i12(4'ha, 5'd13, 5'd0, 12'd4));
        emit(enc_b26(6'h15, 26'd2));
        emit(enc_i12(4'ha, 5'd13, 5'd0, 12'd5));
        emit(enc_u20(7'b0001110, 5'd7, 20'h0));
        emit(enc_b16(6'h13, 5'd7, 5'd8, 16'd4));    // jirl to pcaddu12i pc + 16
        emit(enc_i12(4'ha, 5'd13, 5'd0, 12'd6));
        emit(enc_i12(4'ha, 5'd13, 5'd0, 12'd7));
        emit(enc_3r(5'h00, 5'd14, 5'd1, 5'd8));
    endtask

    task automatic reset_and_sequence_test();
        emit(enc_i12(4'ha, 5'd1, 5'd0, 12'd1));
        emit(enc_i12(4'ha, 5'd2, 5'd1, 12'd2));
        emit(enc_i12(4'ha, 5'd3, 5'd2, 12'd3));
        emit(enc_i12(4'he, 5'd4, 5'd0, 12'h010));
        emit(HALT);
        run_program(1'b0);
    endtask

    task automatic alu_random_test();
        alu_body();
        emit(HALT);
        run_program(1'b0);
    endtask

    task automatic forwarding_test();
        forwarding_body();
        emit(HALT);
        run_program(1'b0);
    endtask

    task automatic branch_test();
        branch_body();
        emit(HALT);
        run_program(1'b0);
    endtask

    task automatic hold_test();
        alu_body();
        forwarding_body();
        branch_body();
        emit(HALT);
        run_program(1'b1);
    endtask

    initial begin
        resetn      = 1'b0;
        hold        = 1'b0;
        rng_state   = 32'd76;
        cycle_count = 0;
        for (int i = 0; i < IMEM_WORDS; i++)
            imem[i] = HALT;
        reset_and_sequence_test();
        alu_random_test();
        forwarding_test();
        branch_test();
        hold_test();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// first fetch address out of reset
`define RESET_PC 32'h1c00_0000

// general purpose registers, r0 included
`define NUM_REGS 32

`endif

// ==== verilog/core_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module core_top import pipe_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    output logic [31:0] inst_addr,
    input  logic [31:0] inst_rdata,
    input  logic        hold,
    output logic        retire_valid,
    output retire_t     retire
);

    logic        fs2ds_valid;
    fs2ds_bus_t  fs2ds_bus;
    logic        ds_allowin;
    br_bus_t     br_bus;
    logic        es_allowin;
    logic        ds2es_valid;
    ds2es_bus_t  ds2es_bus;
    fwd_t        es_fwd;
    logic [4:0]  rf_raddr1;
    logic [4:0]  rf_raddr2;
    logic [31:0] rf_rdata1;
    logic [31:0] rf_rdata2;
    logic        rf_we;
    logic [4:0]  rf_waddr;
    logic [31:0] rf_wdata;

    fetch_stage fetch_stage_inst (
        .clk         (clk),
        .resetn      (resetn),
        .inst_addr   (inst_addr),
        .inst_rdata  (inst_rdata),
        .br_bus      (br_bus),
        .ds_allowin  (ds_allowin),
        .fs2ds_valid (fs2ds_valid),
        .fs2ds_bus   (fs2ds_bus)
    );

    decode_stage decode_stage_inst (
        .clk         (clk),
        .resetn      (resetn),
        .fs2ds_valid (fs2ds_valid),
        .fs2ds_bus   (fs2ds_bus),
        .ds_allowin  (ds_allowin),
        .br_bus      (br_bus),
        .es_allowin  (es_allowin),
        .ds2es_valid (ds2es_valid),
        .ds2es_bus   (ds2es_bus),
        .es_fwd      (es_fwd),
        .rf_raddr1   (rf_raddr1),
        .rf_raddr2   (rf_raddr2),
        .rf_rdata1   (rf_rdata1),
        .rf_rdata2   (rf_rdata2)
    );

    regfile regfile_inst (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .rdata1 (rf_rdata1),
        .raddr2 (rf_raddr2),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    execute_stage execute_stage_inst (
        .clk          (clk),
        .resetn       (resetn),
        .hold         (hold),
        .ds2es_valid  (ds2es_valid),
        .ds2es_bus    (ds2es_bus),
        .es_allowin   (es_allowin),
        .es_fwd       (es_fwd),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

`default_nettype wire

// ==== verilog/decode_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module decode_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  logic        fs2ds_valid,
    input  fs2ds_bus_t  fs2ds_bus,
    output logic        ds_allowin,
    output br_bus_t     br_bus,
    input  logic        es_allowin,
    output logic        ds2es_valid,
    output ds2es_bus_t  ds2es_bus,
    input  fwd_t        es_fwd,
    output logic [4:0]  rf_raddr1,
    output logic [4:0]  rf_raddr2,
    input  logic [31:0] rf_rdata1,
    input  logic [31:0] rf_rdata2
);

    logic        ds_valid;
    logic [31:0] ds_pc;
    inst_word_u  ds_inst;
    fmt_reg_t    reg_view;
    fmt_imm_t    imm_view;

    logic op_zero, is_3r, is_shi;
    logic inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic inst_and, inst_or, inst_xor, inst_nor;
    logic inst_sll_w, inst_srl_w, inst_sra_w;
    logic inst_slli_w, inst_srli_w, inst_srai_w;
    logic inst_addi_w, inst_slti, inst_sltui, inst_andi, inst_ori, inst_xori;
    logic inst_lu12i_w, inst_pcaddu12i;
    logic inst_b, inst_bl, inst_jirl, inst_beq, inst_bne;

    logic        src1_is_pc;
    logic        src2_is_imm;
    logic        src2_is_4;
    logic        src_reg_is_rd;
    logic        gr_we;
    logic [4:0]  dest;
    alu_op_t     alu_op;
    imm_kind_t   imm_kind;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;
    logic [31:0] imm;
    logic [31:0] br_offs;
    logic [31:0] br_target;
    logic        br_taken;
    logic        rj_eq_rd;
    logic        fwd_hit1;
    logic        fwd_hit2;
    logic [31:0] rj_value;
    logic [31:0] rkd_value;

    assign ds_allowin  = !ds_valid || es_allowin;
    assign ds2es_valid = ds_valid;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ds_valid <= 1'b0;
        end else if (br_taken) begin
            ds_valid <= 1'b0;   // fetch output is the wrong path
        end else if (ds_allowin) begin
            ds_valid <= fs2ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs2ds_valid && ds_allowin) begin
            ds_pc   <= fs2ds_bus.pc;
            ds_inst <= fs2ds_bus.inst;
        end
    end

    assign reg_view = ds_inst.fmt_reg;
    assign imm_view = ds_inst.fmt_imm;

    assign op_zero = reg_view.op_31_26 == 6'h00;
    assign is_3r   = op_zero && reg_view.op_25_22 == 4'h0 && reg_view.op_21_20 == 2'h1;
    assign is_shi  = op_zero && reg_view.op_25_22 == 4'h1 && reg_view.op_21_20 == 2'h0;

    assign inst_add_w  = is_3r && reg_view.op_19_15 == 5'h00;
    assign inst_sub_w  = is_3r && reg_view.op_19_15 == 5'h02;
    assign inst_slt    = is_3r && reg_view.op_19_15 == 5'h04;
    assign inst_sltu   = is_3r && reg_view.op_19_15 == 5'h05;
    assign inst_nor    = is_3r && reg_view.op_19_15 == 5'h08;
    assign inst_and    = is_3r && reg_view.op_19_15 == 5'h09;
    assign inst_or     = is_3r && reg_view.op_19_15 == 5'h0a;
    assign inst_xor    = is_3r && reg_view.op_19_15 == 5'h0b;
    assign inst_sll_w  = is_3r && reg_view.op_19_15 == 5'h0e;
    assign inst_srl_w  = is_3r && reg_view.op_19_15 == 5'h0f;
    assign inst_sra_w  = is_3r && reg_view.op_19_15 == 5'h10;
    assign inst_slli_w = is_shi && reg_view.op_19_15 == 5'h01;
    assign inst_srli_w = is_shi && reg_view.op_19_15 == 5'h09;
    assign inst_srai_w = is_shi && reg_view.op_19_15 == 5'h11;
    assign inst_slti   = op_zero && reg_view.op_25_22 == 4'h8;
    assign inst_sltui  = op_zero && reg_view.op_25_22 == 4'h9;
    assign inst_addi_w = op_zero && reg_view.op_25_22 == 4'ha;
    assign inst_andi   = op_zero && reg_view.op_25_22 == 4'hd;
    assign inst_ori    = op_zero && reg_view.op_25_22 == 4'he;
    assign inst_xori   = op_zero && reg_view.op_25_22 == 4'hf;

    assign inst_lu12i_w   = reg_view.op_31_26 == 6'h05 && !reg_view.op_25_22[3];
    assign inst_pcaddu12i = reg_view.op_31_26 == 6'h07 && !reg_view.op_25_22[3];
    assign inst_jirl      = reg_view.op_31_26 == 6'h13;
    assign inst_b         = reg_view.op_31_26 == 6'h14;
    assign inst_bl        = reg_view.op_31_26 == 6'h15;
    assign inst_beq       = reg_view.op_31_26 == 6'h16;
    assign inst_bne       = reg_view.op_31_26 == 6'h17;

    always_comb begin
        alu_op          = '0;
        alu_op.op_add   = inst_add_w | inst_addi_w | inst_jirl | inst_bl | inst_pcaddu12i;
        alu_op.op_sub   = inst_sub_w;
        alu_op.op_slt   = inst_slt | inst_slti;
        alu_op.op_sltu  = inst_sltu | inst_sltui;
        alu_op.op_and   = inst_and | inst_andi;
        alu_op.op_nor   = inst_nor;
        alu_op.op_or    = inst_or | inst_ori;
        alu_op.op_xor   = inst_xor | inst_xori;
        alu_op.op_sll   = inst_sll_w | inst_slli_w;
        alu_op.op_srl   = inst_srl_w | inst_srli_w;
        alu_op.op_sra   = inst_sra_w | inst_srai_w;
        alu_op.op_lui   = inst_lu12i_w;
    end

    assign src1_is_pc    = inst_jirl | inst_bl | inst_pcaddu12i;
    assign src2_is_4     = inst_jirl | inst_bl;   // link value is pc + 4
    assign src2_is_imm   = src2_is_4 | inst_slli_w | inst_srli_w | inst_srai_w | inst_addi_w
                         | inst_slti | inst_sltui | inst_andi | inst_ori | inst_xori
                         | inst_lu12i_w | inst_pcaddu12i;
    assign src_reg_is_rd = inst_beq | inst_bne;
    assign gr_we         = !(inst_beq || inst_bne || inst_b);
    assign dest          = inst_bl ? 5'd1 : reg_view.rd;

    assign i16 = {imm_view.i16_hi, imm_view.i12};
    assign i20 = {imm_view.i16_hi[2:0], imm_view.i12, imm_view.i26_hi[9:5]};
    assign i26 = {imm_view.i26_hi, imm_view.i16_hi, imm_view.i12};

    always_comb begin
        if (src2_is_4)
            imm_kind = IMM_FOUR;
        else if (inst_lu12i_w || inst_pcaddu12i)
            imm_kind = IMM_SI20;
        else if (inst_slli_w || inst_srli_w || inst_srai_w)
            imm_kind = IMM_UI5;
        else if (inst_andi || inst_ori || inst_xori)
            imm_kind = IMM_UI12;
        else
            imm_kind = IMM_SI12;
    end

    always_comb begin
        case (imm_kind)
            IMM_UI5:  imm = {27'b0, imm_view.i12[4:0]};
            IMM_UI12: imm = {20'b0, imm_view.i12};
            IMM_SI20: imm = {i20, 12'b0};
            IMM_FOUR: imm = 32'd4;
            default:  imm = {{20{imm_view.i12[11]}}, imm_view.i12};
        endcase
    end

    // only execute can hold a newer value than the regfile
    assign rf_raddr1 = reg_view.rj;
    assign rf_raddr2 = src_reg_is_rd ? reg_view.rd : reg_view.rk;
    assign fwd_hit1  = es_fwd.we && rf_raddr1 != 5'd0 && rf_raddr1 == es_fwd.waddr;
    assign fwd_hit2  = es_fwd.we && rf_raddr2 != 5'd0 && rf_raddr2 == es_fwd.waddr;
    assign rj_value  = fwd_hit1 ? es_fwd.wdata : rf_rdata1;
    assign rkd_value = fwd_hit2 ? es_fwd.wdata : rf_rdata2;

    // jirl offset shares the si16 form with beq and bne
    assign br_offs   = (inst_b || inst_bl) ? {{4{i26[25]}}, i26, 2'b0}
                                           : {{14{i16[15]}}, i16, 2'b0};
    assign br_target = (inst_jirl ? rj_value : ds_pc) + br_offs;
    assign rj_eq_rd  = rj_value == rkd_value;

    // redirect only on the edge the branch moves on to execute
    assign br_taken = ds_valid && es_allowin
                   && (inst_beq && rj_eq_rd || inst_bne && !rj_eq_rd
                       || inst_jirl || inst_bl || inst_b);
    assign br_bus   = '{taken: br_taken, target: br_target};

    assign ds2es_bus = '{
        alu_op:   alu_op,
        src1:     src1_is_pc ? ds_pc : rj_value,
        src2:     src2_is_imm ? imm : rkd_value,
        rf_we:    gr_we,
        rf_waddr: dest,
        pc:       ds_pc
    };

endmodule

`default_nettype wire

// ==== verilog/execute_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module execute_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  logic        hold,
    input  logic        ds2es_valid,
    input  ds2es_bus_t  ds2es_bus,
    output logic        es_allowin,
    output fwd_t        es_fwd,
    output logic        rf_we,
    output logic [4:0]  rf_waddr,
    output logic [31:0] rf_wdata,
    output logic        retire_valid,
    output retire_t     retire
);

    logic        es_valid;
    ds2es_bus_t  es_bus;
    alu_op_t     op;
    logic [31:0] src1;
    logic [31:0] src2;
    logic [31:0] add_res;
    logic [31:0] sub_res;
    logic [31:0] sll_res;
    logic [31:0] srl_res;
    logic [31:0] sra_res;
    logic        slt_res;
    logic        sltu_res;
    logic [31:0] alu_result;

    assign es_allowin   = !es_valid || !hold;
    assign retire_valid = es_valid && !hold;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds2es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds2es_valid && es_allowin) begin
            es_bus <= ds2es_bus;
        end
    end

    assign op   = es_bus.alu_op;
    assign src1 = es_bus.src1;
    assign src2 = es_bus.src2;

    assign add_res  = src1 + src2;
    assign sub_res  = src1 - src2;
    assign slt_res  = $signed(src1) < $signed(src2);
    assign sltu_res = src1 < src2;
    assign sll_res  = src1 << src2[4:0];
    assign srl_res  = src1 >> src2[4:0];
    assign sra_res  = $signed(src1) >>> src2[4:0];

    // one-hot select, zero when no op bit is set
    assign alu_result = ({32{op.op_add}}  & add_res)
                      | ({32{op.op_sub}}  & sub_res)
                      | ({32{op.op_slt}}  & {31'b0, slt_res})
                      | ({32{op.op_sltu}} & {31'b0, sltu_res})
                      | ({32{op.op_and}}  & (src1 & src2))
                      | ({32{op.op_nor}}  & ~(src1 | src2))
                      | ({32{op.op_or}}   & (src1 | src2))
                      | ({32{op.op_xor}}  & (src1 ^ src2))
                      | ({32{op.op_sll}}  & sll_res)
                      | ({32{op.op_srl}}  & srl_res)
                      | ({32{op.op_sra}}  & sra_res)
                      | ({32{op.op_lui}}  & src2);

    assign es_fwd = '{we: es_valid && es_bus.rf_we, waddr: es_bus.rf_waddr, wdata: alu_result};

    assign rf_we    = retire_valid && es_bus.rf_we;   // write lands on the retire edge
    assign rf_waddr = es_bus.rf_waddr;
    assign rf_wdata = alu_result;

    assign retire = '{
        pc:    es_bus.pc,
        we:    es_bus.rf_we,
        waddr: es_bus.rf_waddr,
        wdata: alu_result
    };

endmodule

`default_nettype wire

// ==== verilog/fetch_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "core_params.svh"

module fetch_stage import pipe_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    output logic [31:0] inst_addr,
    input  logic [31:0] inst_rdata,
    input  br_bus_t     br_bus,
    input  logic        ds_allowin,
    output logic        fs2ds_valid,
    output fs2ds_bus_t  fs2ds_bus
);

    logic [31:0] fs_pc;
    logic [31:0] seq_pc;
    logic [31:0] next_pc;
    logic        fs_valid;

    assign seq_pc  = fs_pc + 32'd4;
    assign next_pc = br_bus.taken ? br_bus.target : seq_pc;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            fs_pc    <= `RESET_PC;
            fs_valid <= 1'b0;
        end else begin
            fs_valid <= !br_bus.taken;   // one bubble after a redirect
            if (br_bus.taken || (fs2ds_valid && ds_allowin)) begin
                fs_pc <= next_pc;
            end
        end
    end

    // imem answers in the same cycle
    assign inst_addr   = fs_pc;
    assign fs2ds_valid = fs_valid;
    assign fs2ds_bus   = '{pc: fs_pc, inst: inst_rdata};

endmodule

`default_nettype wire

// ==== verilog/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    // opcode fields and register numbers
    typedef struct packed {
        logic [5:0] op_31_26;
        logic [3:0] op_25_22;
        logic [1:0] op_21_20;
        logic [4:0] op_19_15;
        logic [4:0] rk;
        logic [4:0] rj;
        logic [4:0] rd;
    } fmt_reg_t;

    // immediate fields, wider offsets are concatenations of these
    typedef struct packed {
        logic [5:0]  op_hi;
        logic [3:0]  i16_hi;     // inst[25:22]
        logic [11:0] i12;        // inst[21:10]
        logic [9:0]  i26_hi;     // inst[9:0]
    } fmt_imm_t;

    typedef union packed {
        fmt_reg_t fmt_reg;
        fmt_imm_t fmt_imm;
    } inst_word_u;

    // one-hot, add in bit 0
    typedef struct packed {
        logic op_lui;
        logic op_sra;
        logic op_srl;
        logic op_sll;
        logic op_xor;
        logic op_or;
        logic op_nor;
        logic op_and;
        logic op_sltu;
        logic op_slt;
        logic op_sub;
        logic op_add;
    } alu_op_t;

    typedef enum logic [2:0] {
        IMM_UI5,
        IMM_UI12,
        IMM_SI12,
        IMM_SI20,
        IMM_FOUR
    } imm_kind_t;

endpackage

`default_nettype wire

// ==== verilog/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

    import isa_pkg::*;

    typedef struct packed {
        logic [31:0] pc;
        inst_word_u  inst;
    } fs2ds_bus_t;

    // redirect from decode back to fetch
    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } br_bus_t;

    typedef struct packed {
        alu_op_t     alu_op;
        logic [31:0] src1;
        logic [31:0] src2;
        logic        rf_we;
        logic [4:0]  rf_waddr;
        logic [31:0] pc;
    } ds2es_bus_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  waddr;
        logic [31:0] wdata;
    } fwd_t;

    // one word per retired instruction
    typedef struct packed {
        logic [31:0] pc;
        logic        we;
        logic [4:0]  waddr;
        logic [31:0] wdata;
    } retire_t;

endpackage

`default_nettype wire

// ==== verilog/regfile.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "core_params.svh"

module regfile (
    input  logic        clk,
    input  logic [4:0]  raddr1,
    output logic [31:0] rdata1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    logic [31:0] regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 never holds anything
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

`default_nettype wire
